// File: rtl/conv_pkg.sv
// shared widths and vector types for the 5x5 bit-sliced convolution
// unsigned data only; a window and a kernel keep tap 0 in the lowest bits
`default_nettype none

package conv_pkg;

  // taps per kernel and pixels per window
  localparam int TAPS = 25;
  localparam int PIXEL_W = 6;
  // each pixel is split into a high and a low slice of this width
  localparam int SLICE_W = 3;
  localparam int FIFO_DEPTH = 4;

  typedef logic [PIXEL_W-1:0] pixel_t;
  typedef logic [PIXEL_W-1:0] weight_t;
  typedef logic [SLICE_W-1:0] slice_t;

  // flattened, first pixel received sits at tap 0
  typedef logic [TAPS*PIXEL_W-1:0] window_t;
  typedef logic [TAPS*PIXEL_W-1:0] kernel_t;

  // 25 * 7 * 63 = 11025 per slice unit
  typedef logic [14:0] slice_sum_t;
  // 25 * 63 * 63 = 99225 for the full result
  typedef logic [17:0] conv_sum_t;

  typedef logic [4:0] tap_idx_t;
  typedef logic [2:0] fifo_cnt_t;

endpackage

`default_nettype wire

// File: rtl/window_collector.sv
// groups every 25 strobed pixels into one window, no 2D line buffering
// upstream must deliver the pixels of a window in tap order
`default_nettype none
`timescale 1ns/1ns

module window_collector (
  input  logic              clk,
  input  logic              rst_n,
  input  conv_pkg::pixel_t  pixel,
  input  logic              pixel_valid,
  output conv_pkg::window_t window,
  output logic              window_strobe
);

  conv_pkg::tap_idx_t tap_idx;
  logic               last_tap;

  assign last_tap = (tap_idx == conv_pkg::tap_idx_t'(conv_pkg::TAPS - 1));

  // tap counter and completion pulse
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      tap_idx       <= '0;
      window_strobe <= 1'b0;
    end
    else
    begin
      window_strobe <= pixel_valid && last_tap;
      if (pixel_valid)
      begin
        if (last_tap)
          tap_idx <= '0;
        else
          tap_idx <= tap_idx + 1'b1;
      end
    end
  end

  // pixel storage, written in place at the current tap
  always_ff @(posedge clk)
  begin
    if (pixel_valid)
      window[tap_idx*conv_pkg::PIXEL_W +: conv_pkg::PIXEL_W] <= pixel;
  end

endmodule

`default_nettype wire

// File: rtl/window_fifo.sv
// four-entry window buffer; a push into a full buffer without a pop is
// dropped and sets overflow, which stays high until reset
`default_nettype none
`timescale 1ns/1ns

module window_fifo (
  input  logic              clk,
  input  logic              rst_n,
  input  conv_pkg::window_t push_window,
  input  logic              push,
  input  logic              pop,
  output conv_pkg::window_t head_window,
  output logic              not_empty,
  output logic              overflow
);

  localparam int PTR_W = $clog2(conv_pkg::FIFO_DEPTH);

  conv_pkg::window_t   mem [conv_pkg::FIFO_DEPTH];
  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;
  conv_pkg::fifo_cnt_t count;
  logic                full;
  logic                do_push;
  logic                do_pop;

  assign full      = (count == conv_pkg::fifo_cnt_t'(conv_pkg::FIFO_DEPTH));
  assign not_empty = (count != '0);
  assign do_pop    = pop && not_empty;
  // a pop in the same cycle frees the slot for the incoming window
  assign do_push   = push && (!full || do_pop);

  assign head_window = mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
      if (push && !do_push)
        overflow <= 1'b1;
    end
  end

  // window storage
  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= push_window;
  end

endmodule

`default_nettype wire

// File: rtl/kernel_bank.sv
// single kernel page of 25 weights loaded from a strobe stream
// a reload overwrites in place; kernel_ready stays high once set
`default_nettype none
`timescale 1ns/1ns

module kernel_bank (
  input  logic              clk,
  input  logic              rst_n,
  input  conv_pkg::weight_t weight,
  input  logic              weight_valid,
  output conv_pkg::kernel_t kernel,
  output logic              kernel_ready
);

  conv_pkg::tap_idx_t w_idx;
  logic               last_tap;

  assign last_tap = (w_idx == conv_pkg::tap_idx_t'(conv_pkg::TAPS - 1));

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      w_idx        <= '0;
      kernel_ready <= 1'b0;
    end
    else if (weight_valid)
    begin
      if (last_tap)
      begin
        w_idx        <= '0;
        kernel_ready <= 1'b1;
      end
      else
        w_idx <= w_idx + 1'b1;
    end
  end

  // weight slots
  always_ff @(posedge clk)
  begin
    if (weight_valid)
      kernel[w_idx*conv_pkg::PIXEL_W +: conv_pkg::PIXEL_W] <= weight;
  end

endmodule

`default_nettype wire

// File: rtl/bit_slice_mac.sv
// one slice unit: dot product of 25 three-bit slices with the kernel
// exact sum, no ADC quantization, registered every cycle
`default_nettype none
`timescale 1ns/1ns

module bit_slice_mac (
  input  logic                                        clk,
  input  logic [conv_pkg::TAPS*conv_pkg::SLICE_W-1:0] slices,
  input  conv_pkg::kernel_t                           kernel,
  output conv_pkg::slice_sum_t                        sum
);

  conv_pkg::slice_sum_t dot;

  // multiply and accumulate across all taps
  always_comb
  begin
    conv_pkg::slice_sum_t acc;
    conv_pkg::slice_t     s;
    conv_pkg::weight_t    w;
    acc = '0;
    for (int i = 0; i < conv_pkg::TAPS; i++)
    begin
      s   = slices[i*conv_pkg::SLICE_W +: conv_pkg::SLICE_W];
      w   = kernel[i*conv_pkg::PIXEL_W +: conv_pkg::PIXEL_W];
      acc = acc + conv_pkg::slice_sum_t'(s) * conv_pkg::slice_sum_t'(w);
    end
    dot = acc;
  end

  always_ff @(posedge clk)
  begin
    sum <= dot;
  end

endmodule

`default_nettype wire

// File: rtl/conv5x5_engine.sv
// pops a window whenever one is buffered, the kernel is loaded and hold is low
// result_valid follows a pop by exactly 2 cycles; two windows may be in flight
`default_nettype none
`timescale 1ns/1ns

module conv5x5_engine (
  input  logic                clk,
  input  logic                rst_n,
  input  conv_pkg::window_t   head_window,
  input  logic                not_empty,
  input  conv_pkg::kernel_t   kernel,
  input  logic                kernel_ready,
  input  logic                hold,
  output logic                pop,
  output conv_pkg::conv_sum_t result,
  output logic                result_valid
);

  logic [conv_pkg::TAPS*conv_pkg::SLICE_W-1:0] hi_slices;
  logic [conv_pkg::TAPS*conv_pkg::SLICE_W-1:0] lo_slices;
  conv_pkg::slice_sum_t                        hi_sum;
  conv_pkg::slice_sum_t                        lo_sum;
  logic                                        sum_valid;

  assign pop = not_empty && kernel_ready && !hold;

  // split each pixel into its high and low slice
  for (genvar g = 0; g < conv_pkg::TAPS; g++)
  begin : g_split
    assign hi_slices[g*conv_pkg::SLICE_W +: conv_pkg::SLICE_W] =
      head_window[g*conv_pkg::PIXEL_W + conv_pkg::SLICE_W +: conv_pkg::SLICE_W];
    assign lo_slices[g*conv_pkg::SLICE_W +: conv_pkg::SLICE_W] =
      head_window[g*conv_pkg::PIXEL_W +: conv_pkg::SLICE_W];
  end

  bit_slice_mac slice_hi (
    .clk    (clk),
    .slices (hi_slices),
    .kernel (kernel),
    .sum    (hi_sum)
  );

  bit_slice_mac slice_lo (
    .clk    (clk),
    .slices (lo_slices),
    .kernel (kernel),
    .sum    (lo_sum)
  );

  // valid pipeline tracking popped windows
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      sum_valid    <= 1'b0;
      result_valid <= 1'b0;
    end
    else
    begin
      sum_valid    <= pop;
      result_valid <= sum_valid;
    end
  end

  // high partial sum weighs 8x the low one
  always_ff @(posedge clk)
  begin
    if (sum_valid)
      result <= (conv_pkg::conv_sum_t'(hi_sum) << conv_pkg::SLICE_W)
                + conv_pkg::conv_sum_t'(lo_sum);
  end

endmodule

`default_nettype wire

// File: rtl/conv_top.sv
// streaming 5x5 convolution; no handshake, windows arrive as 25 ordered pixels
// hold stalls new pops; with an idle buffer the latency is 4 cycles
`default_nettype none
`timescale 1ns/1ns

module conv_top (
  input  logic                clk,
  input  logic                rst_n,
  input  conv_pkg::pixel_t    pixel,
  input  logic                pixel_valid,
  input  conv_pkg::weight_t   weight,
  input  logic                weight_valid,
  input  logic                hold,
  output conv_pkg::conv_sum_t result,
  output logic                result_valid,
  output logic                kernel_ready,
  output logic                overflow
);

  conv_pkg::window_t window;
  logic              window_strobe;
  conv_pkg::window_t head_window;
  logic              not_empty;
  logic              pop;
  conv_pkg::kernel_t kernel;

  window_collector window_collector_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .pixel         (pixel),
    .pixel_valid   (pixel_valid),
    .window        (window),
    .window_strobe (window_strobe)
  );

  // decouples bursty windows from a stalled engine
  window_fifo window_fifo_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_window (window),
    .push        (window_strobe),
    .pop         (pop),
    .head_window (head_window),
    .not_empty   (not_empty),
    .overflow    (overflow)
  );

  kernel_bank kernel_bank_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .weight       (weight),
    .weight_valid (weight_valid),
    .kernel       (kernel),
    .kernel_ready (kernel_ready)
  );

  conv5x5_engine conv5x5_engine_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .head_window  (head_window),
    .not_empty    (not_empty),
    .kernel       (kernel),
    .kernel_ready (kernel_ready),
    .hold         (hold),
    .pop          (pop),
    .result       (result),
    .result_valid (result_valid)
  );

endmodule

`default_nettype wire

// File: testbench/tb_conv_top.sv
// random self-checking testbench for conv_top, LFSR seeded with 68
// windows are sent as 25 ordered pixels; stops at the first error
`default_nettype none
`timescale 1ns/1ns

module tb_conv_top;

  logic                clk;
  logic                rst_n;
  conv_pkg::pixel_t    pixel;
  logic                pixel_valid;
  conv_pkg::weight_t   weight;
  logic                weight_valid;
  logic                hold;
  conv_pkg::conv_sum_t result;
  logic                result_valid;
  logic                kernel_ready;
  logic                overflow;

  logic [15:0]         lfsr_state = 16'd68;
  conv_pkg::weight_t   kern_model [conv_pkg::TAPS];
  conv_pkg::conv_sum_t expected [$];
  int                  results_seen = 0;
  int                  seen_before;

  conv_top conv_top_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .pixel        (pixel),
    .pixel_valid  (pixel_valid),
    .weight       (weight),
    .weight_valid (weight_valid),
    .hold         (hold),
    .result       (result),
    .result_valid (result_valid),
    .kernel_ready (kernel_ready),
    .overflow     (overflow)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic int unsigned rand_bits(input int n);
    int unsigned val;
    val = 0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      val = (val << 1) | lfsr_state[0];
    end
    return val;
  endfunction

  task automatic abort_run();
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_sum(input conv_pkg::conv_sum_t got, input conv_pkg::conv_sum_t exp,
                           input string what);
    if (got !== exp)
    begin
      $display("mismatch at %0t: %s got %0d, expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  // mode 0 random, 1 all ones
  task automatic pick_kernel(input int mode);
    for (int t = 0; t < conv_pkg::TAPS; t++)
      kern_model[t] = (mode == 1) ? 6'd63 : conv_pkg::weight_t'(rand_bits(6));
  endtask

  task automatic load_kernel();
    for (int t = 0; t < conv_pkg::TAPS; t++)
    begin
      repeat (rand_bits(2))
      begin
        @(posedge clk);
        weight_valid <= 1'b0;
      end
      @(posedge clk);
      weight       <= kern_model[t];
      weight_valid <= 1'b1;
    end
    @(posedge clk);
    weight_valid <= 1'b0;
  endtask

  // mode 0 random, 1 all 63, 2 all zero
  task automatic send_window(input int mode, input bit expect_result);
    conv_pkg::pixel_t    px;
    conv_pkg::conv_sum_t acc;
    acc = '0;
    for (int t = 0; t < conv_pkg::TAPS; t++)
    begin
      if (mode == 1)
        px = 6'd63;
      else if (mode == 2)
        px = 6'd0;
      else
        px = conv_pkg::pixel_t'(rand_bits(6));
      acc = acc + conv_pkg::conv_sum_t'(px) * conv_pkg::conv_sum_t'(kern_model[t]);
      repeat (rand_bits(2))
      begin
        @(posedge clk);
        pixel_valid <= 1'b0;
      end
      @(posedge clk);
      pixel       <= px;
      pixel_valid <= 1'b1;
    end
    @(posedge clk);
    pixel_valid <= 1'b0;
    if (expect_result)
      expected.push_back(acc);
  endtask

  // each outstanding result gets its own cycle budget
  task automatic drain_results(input int limit);
    int waited;
    int left;
    waited = 0;
    left = expected.size();
    while (expected.size() != 0)
    begin
      @(posedge clk);
      waited++;
      if (expected.size() != left)
      begin
        left = expected.size();
        waited = 0;
      end
      if (waited > limit)
      begin
        $display("timeout: result number %0d never arrived within %0d cycles",
                 results_seen + 1, limit);
        abort_run();
      end
    end
  endtask

  // result monitor, in arrival order
  always @(posedge clk)
  begin
    if (rst_n && result_valid)
    begin
      results_seen++;
      if (expected.size() == 0)
      begin
        $display("error: a result came out with no window outstanding at %0t", $time);
        abort_run();
      end
      else
        check_sum(result, expected.pop_front(), "result");
    end
  end

  initial
  begin
    pixel        <= '0;
    pixel_valid  <= 1'b0;
    weight       <= '0;
    weight_valid <= 1'b0;
    hold         <= 1'b0;
    rst_n        <= 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_flag(result_valid, 1'b0, "result_valid after reset");
    check_flag(kernel_ready, 1'b0, "kernel_ready after reset");
    check_flag(overflow, 1'b0, "overflow after reset");

    // windows wait in the buffer until a kernel is loaded
    pick_kernel(0);
    repeat (3) send_window(0, 1'b1);
    repeat (6) @(posedge clk);
    check_flag(results_seen != 0, 1'b0, "result before kernel load");
    check_flag(kernel_ready, 1'b0, "kernel_ready before weights");
    check_flag(overflow, 1'b0, "overflow before weights");
    load_kernel();
    @(posedge clk);
    check_flag(kernel_ready, 1'b1, "kernel_ready after 25 weights");
    drain_results(40);

    repeat (20) send_window(0, 1'b1);
    drain_results(40);

    // corner values through both slice units
    pick_kernel(1);
    load_kernel();
    send_window(1, 1'b0);
    expected.push_back(18'd99225);
    send_window(2, 1'b0);
    expected.push_back(18'd0);
    drain_results(40);

    // reload while idle
    pick_kernel(0);
    load_kernel();
    repeat (8) send_window(0, 1'b1);
    drain_results(40);

    // back-pressure, windows 5 and 6 are dropped
    check_flag(overflow, 1'b0, "overflow before hold");
    seen_before = results_seen;
    hold <= 1'b1;
    for (int i = 0; i < 6; i++)
      send_window(0, i < 4);
    repeat (3) @(posedge clk);
    check_flag(results_seen != seen_before, 1'b0, "result while hold high");
    check_flag(overflow, 1'b1, "overflow after six held windows");
    hold <= 1'b0;
    drain_results(40);
    repeat (4) send_window(0, 1'b1);
    drain_results(40);
    check_flag(overflow, 1'b1, "overflow after later windows");
    repeat (10) @(posedge clk);

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
rtl/conv_pkg.sv
rtl/window_collector.sv
rtl/window_fifo.sv
rtl/kernel_bank.sv
rtl/bit_slice_mac.sv
rtl/conv5x5_engine.sv
rtl/conv_top.sv
testbench/tb_conv_top.sv
